//--- build.f
rtl/i2c_cfg_pkg.sv
rtl/i2c_proto_pkg.sv
rtl/i2c_phase_if.sv
rtl/i2c_cmd_decode.sv
rtl/i2c_bit_engine.sv
rtl/i2c_result.sv
rtl/i2c_master_top.sv
tests/i2c_eeprom_model.sv
tests/tb_i2c_master.sv

//--- rtl/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine #(
  parameter int unsigned CLK_FREQ = i2c_cfg_pkg::clk_freq_def,
  parameter int unsigned I2C_FREQ = i2c_cfg_pkg::i2c_freq_def
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_sda,
  output logic        o_scl,
  output logic        o_sda_low,
  i2c_phase_if.engine ph
);
  import i2c_cfg_pkg::*;
  import i2c_proto_pkg::*;

  localparam int unsigned DIV_RAW  = CLK_FREQ / (4 * I2C_FREQ);
  localparam tick_cnt_t   TICK_DIV = (DIV_RAW < 1) ? tick_cnt_t'(1) : tick_cnt_t'(DIV_RAW);

  logic       active;
  tick_cnt_t  div_cnt;
  logic       tick;
  qtr_cnt_t   qtr;
  qtr_cnt_t   last_q;
  qtr_cnt_t   body_q;
  logic       in_pre;
  logic       in_body;
  logic       is_rd;
  logic [3:0] bit_idx;
  logic [1:0] sub;
  logic       data_bit;
  data_t      tx_shift;
  data_t      rx_shift;

  //--------------------------------------------------------------------
  // quarter-bit tick and position inside the phase
  //--------------------------------------------------------------------
  assign tick = active && (div_cnt == TICK_DIV - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active     <= 1'b0;
      div_cnt    <= '0;
      qtr        <= '0;
      ph.ph_done <= 1'b0;
    end else begin
      ph.ph_done <= 1'b0;
      if (ph.ph_start) begin
        active  <= 1'b1;
        div_cnt <= '0;
        qtr     <= '0;
      end else if (tick) begin
        div_cnt <= '0;
        qtr     <= qtr + 1'b1;
        if (qtr == last_q) begin
          active     <= 1'b0;
          ph.ph_done <= 1'b1;
        end
      end else if (active) begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // address phases carry a 4-tick (re)start in front of the byte
  always_comb begin
    in_pre = 1'b0;
    body_q = qtr;
    case (ph.ph_kind)
      PH_START_ADDR, PH_RESTART_ADDR: begin
        last_q = qtr_cnt_t'(39);
        in_pre = (qtr < qtr_cnt_t'(4));
        body_q = qtr - qtr_cnt_t'(4);
      end
      PH_BYTE_WR, PH_BYTE_RD: last_q = qtr_cnt_t'(35);
      default:                last_q = qtr_cnt_t'(15);  // stop
    endcase
  end

  assign is_rd    = (ph.ph_kind == PH_BYTE_RD);
  assign in_body  = (ph.ph_kind != PH_STOP) && !in_pre;
  assign bit_idx  = body_q[5:2];  // 0..7 data, 8 ack slot
  assign sub      = body_q[1:0];
  assign data_bit = (bit_idx < 4'd8);

  //--------------------------------------------------------------------
  // scl / sda waveform
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_scl      <= 1'b1;  // bus released
      o_sda_low  <= 1'b0;
      ph.rx_nack <= 1'b0;
    end else if (ph.ph_start) begin
      ph.rx_nack <= 1'b0;
    end else if (tick) begin
      if (ph.ph_kind == PH_STOP) begin
        case (qtr)
          qtr_cnt_t'(0): o_sda_low <= 1'b1;  // sda low while scl low
          qtr_cnt_t'(1): o_scl     <= 1'b1;
          qtr_cnt_t'(3): o_sda_low <= 1'b0;  // stop edge, then bus free
          default: ;
        endcase
      end else if (in_pre) begin
        case (qtr[1:0])
          2'd0: o_sda_low <= 1'b0;
          2'd1: o_scl     <= 1'b1;
          2'd2: o_sda_low <= 1'b1;  // start edge with scl high
          2'd3: o_scl     <= 1'b0;
        endcase
      end else begin
        case (sub)
          2'd0: o_sda_low <= !is_rd && data_bit && !tx_shift[7];  // release for ack/nack/rx
          2'd1: o_scl     <= 1'b1;
          2'd2: if (!is_rd && !data_bit) ph.rx_nack <= i_sda;  // slave ack
          2'd3: o_scl     <= 1'b0;
        endcase
      end
    end
  end

  // byte shifting, msb first both ways
  always_ff @(posedge clk) begin
    if (ph.ph_start) begin
      tx_shift <= ph.ph_byte;
    end else if (tick && in_body && data_bit && sub == 2'd3) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
    if (tick && is_rd && data_bit && sub == 2'd2) begin
      rx_shift <= {rx_shift[6:0], i_sda};  // sampled with scl high
    end
  end

  assign ph.rx_byte = rx_shift;

endmodule

//--- rtl/i2c_cfg_pkg.sv
package i2c_cfg_pkg;

  //--------------------------------------------------------------------
  // clock and bus rate defaults
  //--------------------------------------------------------------------
  localparam logic [31:0] clk_freq_def = 32'd50_000_000;  // system clock, Hz
  localparam logic [31:0] i2c_freq_def = 32'd250_000;     // scl rate, Hz

  //--------------------------------------------------------------------
  // counter widths
  //--------------------------------------------------------------------
  // clocks per quarter bit, wide enough for slow scl on a fast clock
  typedef logic [15:0] tick_cnt_t;

  // quarter position inside one phase, longest phase is 40 ticks
  typedef logic [5:0] qtr_cnt_t;

endpackage

//--- rtl/i2c_cmd_decode.sv
`timescale 1ns/1ps

module i2c_cmd_decode #(
  parameter i2c_proto_pkg::dev_addr_t SLAVE_ADDR = i2c_proto_pkg::dev_addr_def
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_cmd_valid,
  input  logic                     i_cmd_read,
  input  logic                     i_cmd_addr16,
  input  i2c_proto_pkg::mem_addr_t i_cmd_addr,
  input  i2c_proto_pkg::data_t     i_cmd_wdata,
  output logic                     o_cmd_ready,
  output logic                     o_busy,
  i2c_phase_if.decoder             ph
);
  import i2c_proto_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_ADDR_HI,
    ST_ADDR_LO,
    ST_WDATA,
    ST_RESTART,
    ST_RDATA,
    ST_STOP
  } state_e;

  state_e    state;
  state_e    next_st;
  logic      accept;
  logic      cmd_read;
  logic      cmd_addr16;
  mem_addr_t cmd_addr;
  data_t     cmd_wdata;

  assign o_cmd_ready = (state == ST_IDLE);
  assign o_busy      = (state != ST_IDLE);
  assign accept      = i_cmd_valid && o_cmd_ready;

  // command capture
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_read   <= i_cmd_read;
      cmd_addr16 <= i_cmd_addr16;
      cmd_addr   <= i_cmd_addr;
      cmd_wdata  <= i_cmd_wdata;
    end
  end

  //--------------------------------------------------------------------
  // phase sequence
  //--------------------------------------------------------------------
  always_comb begin
    next_st = ST_IDLE;
    case (state)
      ST_START:   next_st = cmd_addr16 ? ST_ADDR_HI : ST_ADDR_LO;
      ST_ADDR_HI: next_st = ST_ADDR_LO;
      ST_ADDR_LO: next_st = cmd_read ? ST_RESTART : ST_WDATA;  // dummy write ends here
      ST_WDATA:   next_st = ST_STOP;
      ST_RESTART: next_st = ST_RDATA;
      ST_RDATA:   next_st = ST_STOP;
      default:    next_st = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      ph.ph_start <= 1'b0;
    end else begin
      ph.ph_start <= 1'b0;
      if (accept) begin
        state       <= ST_START;
        ph.ph_start <= 1'b1;  // first phase right after accept
      end else if (ph.ph_done) begin
        state       <= next_st;
        ph.ph_start <= (next_st != ST_IDLE);
      end
    end
  end

  // phase request follows the state, so it holds for the whole phase
  always_comb begin
    ph.ph_kind = PH_STOP;
    ph.ph_byte = '0;
    case (state)
      ST_START: begin
        ph.ph_kind = PH_START_ADDR;
        ph.ph_byte = {SLAVE_ADDR, rw_write_bit};
      end
      ST_ADDR_HI: begin
        ph.ph_kind = PH_BYTE_WR;
        ph.ph_byte = cmd_addr[15:8];
      end
      ST_ADDR_LO: begin
        ph.ph_kind = PH_BYTE_WR;
        ph.ph_byte = cmd_addr[7:0];
      end
      ST_WDATA: begin
        ph.ph_kind = PH_BYTE_WR;
        ph.ph_byte = cmd_wdata;
      end
      ST_RESTART: begin
        ph.ph_kind = PH_RESTART_ADDR;
        ph.ph_byte = {SLAVE_ADDR, rw_read_bit};
      end
      ST_RDATA:   ph.ph_kind = PH_BYTE_RD;  // nothing to send
      default:    ph.ph_kind = PH_STOP;
    endcase
  end

endmodule

//--- rtl/i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top #(
  parameter i2c_proto_pkg::dev_addr_t SLAVE_ADDR = i2c_proto_pkg::dev_addr_def,
  parameter int unsigned              CLK_FREQ   = i2c_cfg_pkg::clk_freq_def,
  parameter int unsigned              I2C_FREQ   = i2c_cfg_pkg::i2c_freq_def
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // command handshake
  input  logic                     i_cmd_valid,
  output logic                     o_cmd_ready,
  input  logic                     i_cmd_read,    // 1 = random read
  input  logic                     i_cmd_addr16,  // 1 = two address bytes
  input  i2c_proto_pkg::mem_addr_t i_cmd_addr,
  input  i2c_proto_pkg::data_t     i_cmd_wdata,

  // result
  output i2c_proto_pkg::data_t     o_rdata,
  output logic                     o_done,
  output logic                     o_nack,
  output logic                     o_busy,

  // i2c bus, sda split into pull-down and sense
  output logic                     o_scl,
  output logic                     o_sda_low,
  input  logic                     i_sda
);

  i2c_phase_if ph_if ();

  //--------------------------------------------------------------------
  // decode -> bit engine -> result
  //--------------------------------------------------------------------
  i2c_cmd_decode #(
    .SLAVE_ADDR (SLAVE_ADDR)
  ) decode_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd_read   (i_cmd_read),
    .i_cmd_addr16 (i_cmd_addr16),
    .i_cmd_addr   (i_cmd_addr),
    .i_cmd_wdata  (i_cmd_wdata),
    .o_cmd_ready  (o_cmd_ready),
    .o_busy       (o_busy),
    .ph           (ph_if.decoder)
  );

  i2c_bit_engine #(
    .CLK_FREQ (CLK_FREQ),
    .I2C_FREQ (I2C_FREQ)
  ) engine_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_sda     (i_sda),
    .o_scl     (o_scl),
    .o_sda_low (o_sda_low),
    .ph        (ph_if.engine)
  );

  i2c_result result_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .ph      (ph_if.monitor),
    .o_rdata (o_rdata),
    .o_done  (o_done),
    .o_nack  (o_nack)
  );

endmodule

//--- rtl/i2c_phase_if.sv
`timescale 1ns/1ps

interface i2c_phase_if;
  import i2c_proto_pkg::*;

  // request side, from the decoder
  logic   ph_start;  // one cycle, only while no phase runs
  phase_e ph_kind;   // held until ph_done
  data_t  ph_byte;   // byte to send, held until ph_done

  // response side, from the bit engine
  logic   ph_done;   // one cycle pulse
  data_t  rx_byte;   // byte shifted in by a read phase
  logic   rx_nack;   // ack slot sampled high

  modport decoder (
    output ph_start, ph_kind, ph_byte,
    input  ph_done
  );

  modport engine (
    input  ph_start, ph_kind, ph_byte,
    output ph_done, rx_byte, rx_nack
  );

  modport monitor (
    input ph_start, ph_kind, ph_byte, ph_done, rx_byte, rx_nack
  );

endinterface

//--- rtl/i2c_proto_pkg.sv
package i2c_proto_pkg;

  //--------------------------------------------------------------------
  // bus level types
  //--------------------------------------------------------------------
  typedef logic [6:0]  dev_addr_t;  // 7-bit slave address
  typedef logic [15:0] mem_addr_t;  // eeprom word address
  typedef logic [7:0]  data_t;      // one byte on the wire

  //--------------------------------------------------------------------
  // frame phases, one per byte slot on the bus
  //--------------------------------------------------------------------
  typedef enum logic [2:0] {
    PH_START_ADDR,    // start + dev addr + write bit
    PH_BYTE_WR,       // byte out + slave ack slot
    PH_RESTART_ADDR,  // repeated start + dev addr + read bit
    PH_BYTE_RD,       // byte in + master nack
    PH_STOP           // stop + bus free time
  } phase_e;

  localparam dev_addr_t dev_addr_def = 7'h50;  // 24xx eeprom

  // appended as lsb of the address byte
  localparam logic rw_write_bit = 1'b0;
  localparam logic rw_read_bit  = 1'b1;

endpackage

//--- rtl/i2c_result.sv
`timescale 1ns/1ps

module i2c_result (
  input  logic                 clk,
  input  logic                 rst_n,
  i2c_phase_if.monitor         ph,
  output i2c_proto_pkg::data_t o_rdata,
  output logic                 o_done,
  output logic                 o_nack
);
  import i2c_proto_pkg::*;

  logic frame_start;
  logic stop_done;
  logic ack_slot_done;

  assign frame_start   = ph.ph_start && (ph.ph_kind == PH_START_ADDR);
  assign stop_done     = ph.ph_done && (ph.ph_kind == PH_STOP);
  assign ack_slot_done = ph.ph_done && (ph.ph_kind != PH_BYTE_RD);  // read ends in master nack

  //--------------------------------------------------------------------
  // sticky nack over one frame
  //--------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_nack <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_done <= stop_done;  // one cycle after the stop phase
      if (frame_start) begin
        o_nack <= 1'b0;
      end else if (ack_slot_done && ph.rx_nack) begin
        o_nack <= 1'b1;
      end
    end
  end

  // read byte
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rdata <= '0;
    end else if (ph.ph_done && ph.ph_kind == PH_BYTE_RD) begin
      o_rdata <= ph.rx_byte;
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the I2C master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_i2c_master -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

//--- tests/i2c_eeprom_model.sv
`timescale 1ns/1ps

module i2c_eeprom_model #(
  parameter logic [6:0] DEV_ADDR = 7'h50
) (
  input  logic clk,
  input  logic i_scl,
  input  logic i_sda,
  input  logic i_addr16,      // 1 = two word address bytes
  input  logic i_force_nack,  // refuse the device address
  output logic o_sda_low
);

  typedef enum logic [1:0] {M_IDLE, M_RX, M_TX} mode_e;

  logic [7:0]  mem [0:65535];
  mode_e       mode;
  logic        scl_q;
  logic        sda_q;
  logic [3:0]  bit_cnt;
  logic [1:0]  byte_idx;
  logic [7:0]  shift;
  logic [7:0]  tx_shift;
  logic        in_ack;
  logic        rd_next;
  logic [15:0] ptr;

  initial begin
    for (int i = 0; i < 65536; i++) begin
      mem[i] <= 8'(i[15:8] ^ i[7:0] ^ 8'h5a);  // fill depends on whole address
    end
    mode      <= M_IDLE;
    scl_q     <= 1'b1;
    sda_q     <= 1'b1;
    o_sda_low <= 1'b0;
    in_ack    <= 1'b0;
    ptr       <= '0;
  end

  //--------------------------------------------------------------------
  // bus sampled on the system clock, edges found from the last sample
  //--------------------------------------------------------------------
  always @(posedge clk) begin
    scl_q <= i_scl;
    sda_q <= i_sda;
    if (scl_q && i_scl && sda_q && !i_sda) begin  // start or repeated start
      mode      <= M_RX;
      bit_cnt   <= '0;
      byte_idx  <= '0;
      in_ack    <= 1'b0;
      o_sda_low <= 1'b0;
    end else if (scl_q && i_scl && !sda_q && i_sda) begin  // stop
      mode      <= M_IDLE;
      o_sda_low <= 1'b0;
    end else if (!scl_q && i_scl) begin  // scl rise
      if (mode == M_RX && !in_ack && bit_cnt < 4'd8) begin
        shift   <= {shift[6:0], i_sda};
        bit_cnt <= bit_cnt + 4'd1;
      end else if (mode == M_TX && bit_cnt == 4'd9) begin
        if (i_sda) begin
          mode <= M_IDLE;  // master nack ends the read
        end else begin
          ptr      <= ptr + 16'd1;
          tx_shift <= mem[ptr + 16'd1];
          bit_cnt  <= '0;
        end
      end
    end else if (scl_q && !i_scl) begin  // scl fall
      if (mode == M_RX && in_ack) begin
        in_ack    <= 1'b0;
        o_sda_low <= 1'b0;
        bit_cnt   <= '0;
        if (rd_next) begin
          mode      <= M_TX;
          o_sda_low <= !tx_shift[7];
          tx_shift  <= {tx_shift[6:0], 1'b0};
          bit_cnt   <= 4'd1;
        end
      end else if (mode == M_RX && bit_cnt == 4'd8) begin
        byte_idx <= byte_idx + 2'd1;
        if (byte_idx == 2'd0) begin
          if (shift[7:1] == DEV_ADDR && !i_force_nack) begin
            in_ack    <= 1'b1;
            o_sda_low <= 1'b1;
            rd_next   <= shift[0];
            tx_shift  <= mem[ptr];
          end else begin
            mode <= M_IDLE;  // not addressed, stay off the bus
          end
        end else begin
          in_ack    <= 1'b1;
          o_sda_low <= 1'b1;
          rd_next   <= 1'b0;
          if (i_addr16 && byte_idx == 2'd1) begin
            ptr[15:8] <= shift;
          end else if (i_addr16 && byte_idx == 2'd2) begin
            ptr[7:0] <= shift;
          end else if (!i_addr16 && byte_idx == 2'd1) begin
            ptr <= {8'h00, shift};
          end else begin
            mem[ptr] <= shift;  // data byte
            ptr      <= ptr + 16'd1;
          end
        end
      end else if (mode == M_TX && bit_cnt < 4'd8) begin
        o_sda_low <= !tx_shift[7];
        tx_shift  <= {tx_shift[6:0], 1'b0};
        bit_cnt   <= bit_cnt + 4'd1;
      end else if (mode == M_TX && bit_cnt == 4'd8) begin
        o_sda_low <= 1'b0;  // let the master ack or nack
        bit_cnt   <= 4'd9;
      end
    end
  end

endmodule

//--- tests/tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master;
  import i2c_proto_pkg::*;

  localparam int N_ROWS      = 12;
  localparam int CYCLE_LIMIT = N_ROWS * 2500 + 100;

  typedef struct {
    bit        rd;
    bit        a16;
    mem_addr_t addr;
    data_t     wdata;
    bit        fnack;
    data_t     exp_rdata;
    bit        exp_nack;
  } row_t;

  logic      clk;
  logic      rst_n;
  logic      cmd_valid;
  logic      cmd_read;
  logic      cmd_addr16;
  mem_addr_t cmd_addr;
  data_t     cmd_wdata;
  logic      cmd_ready;
  logic      scl;
  logic      sda_low;
  logic      sda;
  logic      done;
  logic      nack;
  logic      busy;
  data_t     rdata;
  logic      model_sda_low;
  logic      model_addr16;
  logic      model_force_nack;
  row_t      tbl [N_ROWS];
  int        mismatch_cnt;
  int        fail_cnt = 0;
  int        cycles = 0;
  integer    seed;
  bit        early_accept;

  assign sda = !(sda_low || model_sda_low);  // wired-and with pull-up

  i2c_master_top #(
    .SLAVE_ADDR (7'h50),
    .CLK_FREQ   (10_000_000),
    .I2C_FREQ   (250_000)
  ) dut_i (
    .clk (clk), .rst_n (rst_n),
    .i_cmd_valid (cmd_valid), .o_cmd_ready (cmd_ready), .i_cmd_read (cmd_read),
    .i_cmd_addr16 (cmd_addr16), .i_cmd_addr (cmd_addr), .i_cmd_wdata (cmd_wdata),
    .o_rdata (rdata), .o_done (done), .o_nack (nack), .o_busy (busy),
    .o_scl (scl), .o_sda_low (sda_low), .i_sda (sda)
  );

  i2c_eeprom_model #(.DEV_ADDR (7'h50)) model_i (
    .clk (clk), .i_scl (scl), .i_sda (sda), .i_addr16 (model_addr16),
    .i_force_nack (model_force_nack), .o_sda_low (model_sda_low)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      fail_cnt = fail_cnt + 1;
      $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //--------------------------------------------------------------------
  // checks and helpers
  //--------------------------------------------------------------------
  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected 0x%02h, got 0x%02h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, act);
    end
  endtask

  function automatic row_t make_row(input bit rd, input bit a16, input mem_addr_t addr,
                                    input data_t wdata, input bit fnack, input bit exp_nack);
    row_t r;
    r.rd        = rd;
    r.a16       = a16;
    r.addr      = addr;
    r.wdata     = wdata;
    r.fnack     = fnack;
    r.exp_rdata = wdata;  // reads expect the byte written before
    r.exp_nack  = exp_nack;
    return r;
  endfunction

  task automatic build_table();
    data_t d [6];
    for (int k = 0; k < 6; k++) d[k] = data_t'($random(seed));
    tbl[0]  = make_row(0, 0, 16'h003c, d[0], 0, 0);
    tbl[1]  = make_row(1, 0, 16'h003c, d[0], 0, 0);
    tbl[2]  = make_row(0, 1, 16'h1a5c, d[1], 0, 0);
    tbl[3]  = make_row(1, 1, 16'h1a5c, d[1], 0, 0);
    tbl[4]  = make_row(0, 0, 16'h0010, d[2], 0, 0);
    tbl[5]  = make_row(0, 0, 16'h0020, d[3], 0, 0);
    tbl[6]  = make_row(0, 0, 16'h0030, d[4], 0, 0);
    tbl[7]  = make_row(1, 0, 16'h0020, d[3], 0, 0);
    tbl[8]  = make_row(1, 0, 16'h0030, d[4], 0, 0);
    tbl[9]  = make_row(1, 0, 16'h0010, d[2], 0, 0);
    tbl[10] = make_row(0, 0, 16'h0040, d[5], 1, 1);  // slave refuses address
    tbl[11] = make_row(1, 0, 16'h003c, d[0], 0, 0);
  endtask

  task automatic drive_cmd(input row_t r);
    cmd_valid  <= 1'b1;
    cmd_read   <= r.rd;
    cmd_addr16 <= r.a16;
    cmd_addr   <= r.addr;
    cmd_wdata  <= r.wdata;
  endtask

  task automatic wait_accept();
    if (early_accept) begin
      early_accept = 1'b0;  // taken in the done cycle already
    end else begin
      do @(posedge clk); while (!(cmd_valid && cmd_ready));
    end
  endtask

  // ready stays low while the next command is held
  task automatic wait_done();
    do begin
      @(posedge clk);
      if (busy) check_flag("o_cmd_ready", 1'b0, cmd_ready);
    end while (!done);
    early_accept = cmd_valid && cmd_ready;
  endtask

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------
  initial begin
    seed             = 32'ha66ba639;
    rst_n            = 1'b0;
    cmd_valid        = 1'b0;
    cmd_read         = 1'b0;
    cmd_addr16       = 1'b0;
    cmd_addr         = '0;
    cmd_wdata        = '0;
    model_addr16     = 1'b0;
    model_force_nack = 1'b0;
    mismatch_cnt     = 0;
    early_accept     = 1'b0;
    build_table();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_flag("o_cmd_ready", 1'b1, cmd_ready);
    check_flag("o_busy", 1'b0, busy);
    check_flag("o_done", 1'b0, done);
    check_flag("o_scl", 1'b1, scl);
    check_flag("o_sda_low", 1'b0, sda_low);
    drive_cmd(tbl[0]);
    for (int i = 0; i < N_ROWS; i++) begin
      model_addr16     <= tbl[i].a16;
      model_force_nack <= tbl[i].fnack;
      wait_accept();
      if (i + 1 < N_ROWS) drive_cmd(tbl[i + 1]);
      else cmd_valid <= 1'b0;
      wait_done();
      check_flag("o_nack", tbl[i].exp_nack, nack);
      check_flag("o_busy", 1'b0, busy);
      check_flag("o_scl", 1'b1, scl);  // bus free after the stop
      check_flag("o_sda_low", 1'b0, sda_low);
      if (tbl[i].rd && !tbl[i].exp_nack) check_data("o_rdata", tbl[i].exp_rdata, rdata);
      if (!tbl[i].rd && !tbl[i].fnack) begin
        check_data("mem", tbl[i].wdata,
                   model_i.mem[tbl[i].a16 ? tbl[i].addr : {8'h00, tbl[i].addr[7:0]}]);
      end
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
